// ==== design/riscv_isa_pkg.sv ====
// rv32 instruction set types
`default_nettype none

package riscv_isa_pkg;

  // base integer register width
  localparam int unsigned xlen = 32;

  // data word as seen by the core
  typedef logic [xlen-1:0] word;

  // register index, doubles as the zimm field
  typedef logic [4:0] r;

  // csr address space is 4k entries
  typedef logic [11:0] csr_addr_t;

  // raw instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;

  // major opcode shared by ecall, ebreak and zicsr
  localparam opcode_t opcode_system = 7'b1110011;

  // zicsr operations, encoded as their funct3 value
  // code 0 marks no csr operation
  // code 4 is not a zicsr form
  typedef enum logic [2:0] {
    CSR_IDLE = 3'd0,
    CSRRW    = 3'd1,
    CSRRS    = 3'd2,
    CSRRC    = 3'd3,
    CSRRWI   = 3'd5,
    CSRRSI   = 3'd6,
    CSRRCI   = 3'd7
  } csr_op_t;

endpackage

`default_nettype wire

// ==== design/csr_map_pkg.sv ====
// machine mode csr map
`default_nettype none

package csr_map_pkg;

  import riscv_isa_pkg::*;

  // implemented csr addresses
  localparam csr_addr_t addr_mstatus  = 12'h300;
  localparam csr_addr_t addr_misa     = 12'h301;
  localparam csr_addr_t addr_mtvec    = 12'h305;
  localparam csr_addr_t addr_mscratch = 12'hB00 - 12'h7C0;
  localparam csr_addr_t addr_mcycle   = 12'hB00;

  // only the low byte of mstatus is implemented
  localparam int unsigned mstatus_width = 8;

  // mxl = 1 (rv32), extension bit i
  localparam word misa_value = 32'h4000_0100;

  // trap vector base out of reset
  localparam word mtvec_reset = 32'h0000_0100;

  // one csr access, built by the decoder
  typedef struct packed {
    logic      enable;
    csr_addr_t addr;
    csr_op_t   op;
    r          zimm;
  } csr_req_t;

  // true when the address hits one of the five registers
  function automatic logic csr_is_mapped(csr_addr_t addr);
    case (addr)
      addr_mstatus, addr_misa, addr_mtvec, addr_mscratch, addr_mcycle: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // misa is constant, mcycle only moves by itself
  function automatic logic csr_is_read_only(csr_addr_t addr);
    case (addr)
      addr_misa, addr_mcycle: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/csr.sv ====
// single control and status register
`default_nettype none

module csr
  import riscv_isa_pkg::*;
  import csr_map_pkg::*;
#(
  // implemented bits, at least 5 so zimm fits
  parameter int unsigned CsrWidth = 32,
  parameter logic [CsrWidth-1:0] ResetValue = '0,
  parameter csr_addr_t Addr = '0,
  parameter bit Read = 1'b1,
  parameter bit Write = 1'b1
) (
  input  logic                clk,
  input  logic                reset,
  input  csr_req_t            req,
  input  word                 rs1_data,
  // side effect port, used by counters
  input  logic [CsrWidth-1:0] ext_data,
  input  logic                ext_write_enable,
  output word                 out
);

  typedef logic [CsrWidth-1:0] csr_data_t;

  csr_data_t data;
  csr_data_t rs1_part;
  csr_data_t zimm_ext;
  logic      hit;
  logic      write_enable;
  logic      has_source;

  // address decode for this register
  assign hit = (req.addr == Addr);

  // instruction write path, gated by permission
  assign write_enable = req.enable && hit && Write;

  // set and clear forms only act with a nonzero source field
  assign has_source = (req.zimm != '0);

  // upper bits of rs1 are dropped for narrow registers
  assign rs1_part = rs1_data[CsrWidth-1:0];

  // immediate is zero extended
  assign zimm_ext = csr_data_t'(req.zimm);

  // combinational read, zero unless addressed
  assign out = (Read && hit) ? word'(data) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      data <= ResetValue;
    end else if (ext_write_enable) begin
      // side effect wins over an instruction
      data <= ext_data;
    end else if (write_enable) begin
      case (req.op)
        CSRRW:  data <= rs1_part;
        CSRRS:  if (has_source) data <= data | rs1_part;
        CSRRC:  if (has_source) data <= data & ~rs1_part;
        CSRRWI: data <= zimm_ext;
        CSRRSI: if (has_source) data <= data | zimm_ext;
        CSRRCI: if (has_source) data <= data & ~zimm_ext;
        default: ;
      endcase
    end
  end

  // decoder never enables a request without an operation
  a_enable_has_op : assert property (
    @(posedge clk) disable iff (reset)
    req.enable |-> (req.op != CSR_IDLE)
  );

endmodule

`default_nettype wire

// ==== design/csr_decode.sv ====
// zicsr instruction decoder
`default_nettype none

module csr_decode
  import riscv_isa_pkg::*;
  import csr_map_pkg::*;
(
  input  word      instr,
  input  logic     instr_valid,
  output csr_req_t req,
  output logic     illegal
);

  opcode_t   opcode;
  funct3_t   funct3;
  r          rs1_zimm;
  csr_addr_t addr;
  logic      is_system;
  logic      is_csr_form;
  logic      is_write;
  logic      legal;

  // i-type field split
  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1_zimm = instr[19:15];
  assign addr     = instr[31:20];

  assign is_system = instr_valid && (opcode == opcode_system);

  // funct3 0 is ecall/ebreak, 4 is reserved
  assign is_csr_form = is_system && (funct3 != 3'b000) && (funct3 != 3'b100);

  // csrrw and csrrwi always write
  // set and clear write only with a nonzero rs1 or zimm
  assign is_write = (funct3[1:0] == 2'b01) || (rs1_zimm != '0);

  // unmapped or writing a read only register is rejected
  assign legal = is_csr_form
              && csr_is_mapped(addr)
              && !(is_write && csr_is_read_only(addr));

  // pulse only for csr forms that fail the check
  assign illegal = is_csr_form && !legal;

  always_comb begin
    req = '0;
    // fields follow any csr form so an illegal read still addresses
    if (is_csr_form) begin
      req.addr = addr;
      req.op   = csr_op_t'(funct3);
      req.zimm = rs1_zimm;
    end
    // only legal accesses reach the registers
    req.enable = legal;
  end

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
// machine mode csr register file
`default_nettype none

module csr_file
  import riscv_isa_pkg::*;
  import csr_map_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  csr_req_t req,
  input  word      rs1_data,
  output word      rd_data
);

  word mstatus_out;
  word misa_out;
  word mtvec_out;
  word mscratch_out;
  word mcycle_out;

  // free running cycle count, mirrored into mcycle
  word cycle_count;
  word cycle_next;

  assign cycle_next = cycle_count + 32'd1;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_next;
    end
  end

  // low byte only, upper bits read zero
  csr #(
    .CsrWidth  (mstatus_width),
    .ResetValue('0),
    .Addr      (addr_mstatus),
    .Read      (1'b1),
    .Write     (1'b1)
  ) mstatus_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .rs1_data        (rs1_data),
    .ext_data        ('0),
    .ext_write_enable(1'b0),
    .out             (mstatus_out)
  );

  // constant isa description
  csr #(
    .CsrWidth  (xlen),
    .ResetValue(misa_value),
    .Addr      (addr_misa),
    .Read      (1'b1),
    .Write     (1'b0)
  ) misa_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .rs1_data        (rs1_data),
    .ext_data        ('0),
    .ext_write_enable(1'b0),
    .out             (misa_out)
  );

  csr #(
    .CsrWidth  (xlen),
    .ResetValue(mtvec_reset),
    .Addr      (addr_mtvec),
    .Read      (1'b1),
    .Write     (1'b1)
  ) mtvec_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .rs1_data        (rs1_data),
    .ext_data        ('0),
    .ext_write_enable(1'b0),
    .out             (mtvec_out)
  );

  csr #(
    .CsrWidth  (xlen),
    .ResetValue('0),
    .Addr      (addr_mscratch),
    .Read      (1'b1),
    .Write     (1'b1)
  ) mscratch_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .rs1_data        (rs1_data),
    .ext_data        ('0),
    .ext_write_enable(1'b0),
    .out             (mscratch_out)
  );

  // out is zero unless addressed, so the next count comes from cycle_count
  // loaded every cycle through the side effect port
  csr #(
    .CsrWidth  (xlen),
    .ResetValue('0),
    .Addr      (addr_mcycle),
    .Read      (1'b1),
    .Write     (1'b0)
  ) mcycle_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .rs1_data        (rs1_data),
    .ext_data        (cycle_next),
    .ext_write_enable(1'b1),
    .out             (mcycle_out)
  );

  // at most one register is addressed, the rest drive zero
  assign rd_data = mstatus_out | misa_out | mtvec_out | mscratch_out | mcycle_out;

  // nothing leaks onto the read bus for an idle or unmapped cycle
  a_idle_read_zero : assert property (
    @(posedge clk) disable iff (reset)
    (!req.enable && !csr_is_mapped(req.addr)) |-> (rd_data == '0)
  );

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
// csr unit top level
`default_nettype none

module csr_unit
  import riscv_isa_pkg::*;
  import csr_map_pkg::*;
(
  input  logic clk,
  input  logic reset,
  // one instruction per cycle, no back pressure
  input  word  instr,
  input  logic instr_valid,
  // source register value from the core
  input  word  rs1_data,
  // old csr value, same cycle
  output word  rd_data,
  output logic illegal
);

  // decoded access, shared by all registers
  csr_req_t req;

  csr_decode csr_decode_i (
    .instr      (instr),
    .instr_valid(instr_valid),
    .req        (req),
    .illegal    (illegal)
  );

  // write lands on the next edge
  csr_file csr_file_i (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .rs1_data(rs1_data),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// ==== tests/csr_unit_tb.sv ====
// csr unit directed testbench
`default_nettype none

module csr_unit_tb
  import riscv_isa_pkg::*;
  import csr_map_pkg::*;
();

  // run limit, far above the few hundred cycles the tests take
  localparam int timeout_cycles = 2000;
  localparam int half_period = 10;
  // sample point after the falling edge drive
  localparam int settle_time = 5;

  logic clk;
  logic reset;
  word  instr;
  logic instr_valid;
  word  rs1_data;
  word  rd_data;
  logic illegal;

  // reference model of the writable registers
  word model_mstatus;
  word model_mtvec;
  word model_mscratch;
  // cycles since reset went low
  word model_cycles;

  int error_count;
  int check_count;
  int cycle_counter;

  csr_unit csr_unit_i (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .instr_valid(instr_valid),
    .rs1_data   (rs1_data),
    .rd_data    (rd_data),
    .illegal    (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // mcycle reference, one tick per edge out of reset
  always @(posedge clk) begin
    if (reset) begin
      model_cycles <= '0;
    end else begin
      model_cycles <= model_cycles + 32'd1;
    end
  end

  // watchdog
  initial begin
    cycle_counter = 0;
    while (cycle_counter < timeout_cycles) begin
      @(posedge clk);
      cycle_counter++;
    end
    $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    $display("Test failures found");
    $finish;
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // i-type system encoding, rd fixed to x1
  function automatic word build_instr(csr_op_t op, csr_addr_t addr, r src);
    return {addr, src, funct3_t'(op), 5'd1, opcode_system};
  endfunction

  // value an instruction should read back
  function automatic word model_value(csr_addr_t addr);
    case (addr)
      addr_mstatus:  return model_mstatus;
      addr_misa:     return misa_value;
      addr_mtvec:    return model_mtvec;
      addr_mscratch: return model_mscratch;
      addr_mcycle:   return model_cycles;
      default:       return '0;
    endcase
  endfunction

  // zicsr update rules
  function automatic word next_value(csr_op_t op, word old, r src, word data);
    word zimm_word;
    zimm_word = {27'd0, src};
    case (op)
      CSRRW:   return data;
      CSRRS:   return (src == 5'd0) ? old : (old | data);
      CSRRC:   return (src == 5'd0) ? old : (old & ~data);
      CSRRWI:  return zimm_word;
      CSRRSI:  return (src == 5'd0) ? old : (old | zimm_word);
      CSRRCI:  return (src == 5'd0) ? old : (old & ~zimm_word);
      default: return old;
    endcase
  endfunction

  task automatic store_value(input csr_addr_t addr, input word value);
    case (addr)
      // 8 implemented bits
      addr_mstatus:  model_mstatus = value & 32'h0000_00ff;
      addr_mtvec:    model_mtvec = value;
      addr_mscratch: model_mscratch = value;
      // misa and mcycle never take instruction writes
      default: ;
    endcase
  endtask

  // one csr instruction, then a cycle of idle
  task automatic csr_access(input csr_op_t op, input csr_addr_t addr, input r src,
                            input word data, input logic expect_illegal,
                            output word read_value);
    word expected;
    @(negedge clk);
    instr = build_instr(op, addr, src);
    instr_valid = 1'b1;
    rs1_data = data;
    #settle_time;
    expected = model_value(addr);
    read_value = rd_data;
    check_count++;
    if (illegal !== expect_illegal) begin
      report_error($sformatf("illegal %b, expected %b (%s at %h)",
                             illegal, expect_illegal, op.name(), addr));
    end
    if (!expect_illegal) begin
      check_count++;
      if (rd_data !== expected) begin
        report_error($sformatf("rd_data %h, expected %h (%s at %h)",
                               rd_data, expected, op.name(), addr));
      end
      store_value(addr, next_value(op, expected, src, data));
    end
    @(negedge clk);
    instr = '0;
    instr_valid = 1'b0;
    rs1_data = '0;
  endtask

  // set with x0, never a write
  task automatic read_csr(input csr_addr_t addr, output word value);
    csr_access(CSRRS, addr, 5'd0, word'($urandom), 1'b0, value);
  endtask

  task automatic read_all();
    word value;
    read_csr(addr_mstatus, value);
    read_csr(addr_misa, value);
    read_csr(addr_mtvec, value);
    read_csr(addr_mscratch, value);
    read_csr(addr_mcycle, value);
  endtask

  // cycle that must be ignored by the unit
  task automatic run_other(input word value, input logic valid);
    @(negedge clk);
    instr = value;
    instr_valid = valid;
    rs1_data = word'($urandom);
    #settle_time;
    check_count++;
    if (illegal !== 1'b0) begin
      report_error($sformatf("illegal raised for %h, valid %b", value, valid));
    end
    check_count++;
    if (rd_data !== '0) begin
      report_error($sformatf("rd_data %h, expected 0 for %h", rd_data, value));
    end
    @(negedge clk);
    instr = '0;
    instr_valid = 1'b0;
    rs1_data = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_reset_values();
    word value;
    read_csr(addr_mstatus, value);
    read_csr(addr_misa, value);
    read_csr(addr_mtvec, value);
    read_csr(addr_mscratch, value);
  endtask

  task automatic register_form_ops();
    csr_addr_t targets[2] = '{addr_mscratch, addr_mtvec};
    word value;
    for (int i = 0; i < 2; i++) begin
      for (int k = 0; k < 4; k++) begin
        csr_access(CSRRW, targets[i], 5'd5, word'($urandom), 1'b0, value);
        read_csr(targets[i], value);
        csr_access(CSRRS, targets[i], 5'd6, word'($urandom), 1'b0, value);
        read_csr(targets[i], value);
        csr_access(CSRRC, targets[i], 5'd7, word'($urandom), 1'b0, value);
        read_csr(targets[i], value);
        // x0 source, port data must not land
        csr_access(CSRRC, targets[i], 5'd0, word'($urandom), 1'b0, value);
        read_csr(targets[i], value);
      end
    end
  endtask

  task automatic immediate_form_ops();
    word value;
    r    zimm;
    for (int k = 0; k < 6; k++) begin
      zimm = r'($urandom);
      csr_access(CSRRWI, addr_mscratch, zimm, word'($urandom), 1'b0, value);
      read_csr(addr_mscratch, value);
      zimm = r'($urandom);
      csr_access(CSRRSI, addr_mscratch, zimm, word'($urandom), 1'b0, value);
      read_csr(addr_mscratch, value);
      zimm = r'($urandom);
      csr_access(CSRRCI, addr_mscratch, zimm, word'($urandom), 1'b0, value);
      read_csr(addr_mscratch, value);
    end
    // zero immediate is a plain read
    csr_access(CSRRSI, addr_mscratch, 5'd0, word'($urandom), 1'b0, value);
    csr_access(CSRRCI, addr_mscratch, 5'd0, word'($urandom), 1'b0, value);
    read_csr(addr_mscratch, value);
    // narrow mstatus
    for (int k = 0; k < 4; k++) begin
      csr_access(CSRRW, addr_mstatus, 5'd3, word'($urandom), 1'b0, value);
      read_csr(addr_mstatus, value);
      check_count++;
      if (value[31:8] !== '0) begin
        report_error($sformatf("mstatus upper bits set, read %h", value));
      end
      csr_access(CSRRS, addr_mstatus, 5'd4, word'($urandom), 1'b0, value);
      csr_access(CSRRCI, addr_mstatus, r'($urandom), '0, 1'b0, value);
      read_csr(addr_mstatus, value);
    end
  endtask

  task automatic mcycle_count();
    word first;
    word second;
    int  gap;
    for (int k = 0; k < 4; k++) begin
      gap = int'($urandom_range(20, 1));
      read_csr(addr_mcycle, first);
      idle_cycles(gap);
      read_csr(addr_mcycle, second);
      check_count++;
      // idle cycle after the first read plus the drive edge of the second
      if (second - first !== word'(gap + 2)) begin
        report_error($sformatf("mcycle moved by %0d, expected %0d",
                               second - first, gap + 2));
      end
    end
  endtask

  task automatic illegal_access();
    csr_addr_t unmapped[4] = '{12'h000, 12'h341, 12'h7ff, 12'hc00};
    word value;
    csr_access(CSRRW, addr_misa, 5'd5, word'($urandom), 1'b1, value);
    csr_access(CSRRWI, addr_misa, 5'd9, '0, 1'b1, value);
    csr_access(CSRRSI, addr_misa, 5'd1, '0, 1'b1, value);
    read_csr(addr_misa, value);
    csr_access(CSRRW, addr_mcycle, 5'd5, 32'd0, 1'b1, value);
    csr_access(CSRRC, addr_mcycle, 5'd5, 32'hffff_ffff, 1'b1, value);
    // still counting from reset
    read_csr(addr_mcycle, value);
    for (int i = 0; i < 4; i++) begin
      csr_access(CSRRW, unmapped[i], 5'd5, word'($urandom), 1'b1, value);
      csr_access(CSRRS, unmapped[i], 5'd0, word'($urandom), 1'b1, value);
    end
    read_all();
    csr_access(CSRRS, addr_misa, 5'd0, word'($urandom), 1'b0, value);
    check_count++;
    if (value !== misa_value) begin
      report_error($sformatf("misa read %h, expected %h", value, misa_value));
    end
  endtask

  task automatic non_csr_cycles();
    // addi x1, x0, 5
    run_other(32'h0050_0093, 1'b1);
    // ecall
    run_other(32'h0000_0073, 1'b1);
    // reserved funct3 4
    run_other({addr_mscratch, 5'd1, 3'b100, 5'd1, opcode_system}, 1'b1);
    // csr writes without instr_valid
    run_other(build_instr(CSRRW, addr_mscratch, 5'd5), 1'b0);
    run_other(build_instr(CSRRWI, addr_mtvec, 5'd31), 1'b0);
    run_other(build_instr(CSRRW, addr_misa, 5'd5), 1'b0);
    read_all();
  endtask

  initial begin
    void'($urandom(32'h35a9ef04));
    error_count = 0;
    check_count = 0;
    reset = 1'b1;
    instr = '0;
    instr_valid = 1'b0;
    rs1_data = '0;
    model_mstatus = '0;
    model_mtvec = mtvec_reset;
    model_mscratch = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    check_reset_values();
    register_form_ops();
    immediate_form_ops();
    mcycle_count();
    illegal_access();
    non_csr_cycles();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/riscv_isa_pkg.sv
design/csr_map_pkg.sv
design/csr.sv
design/csr_decode.sv
design/csr_file.sv
design/csr_unit.sv
tests/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the csr unit testbench with verilator

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f \
  --top-module csr_unit_tb -o csr_unit_sim \
  && ./obj_dir/csr_unit_sim > sim.log 2>&1

[ -f sim.log ] && cat sim.log

grep -q 'All tests passed!' sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
